/* rtl/addrgen_defs.svh */
// Address generator parameters
`ifndef ADDRGEN_DEFS_SVH
`define ADDRGEN_DEFS_SVH

// Address bus
`define ADDR_W 32

// Vector length field, elements per instruction
`define VL_W 10

// Data bus, 8 bytes per beat
`define BUS_BYTES 8
`define BUS_SIZE_LOG ($clog2(`BUS_BYTES))

// Burst limits, AXI caps bursts at 256 beats and 4 KiB pages
`define MAX_BURST_BEATS 256
`define PAGE_BITS 12

// Entries in the load/store request queue
`define QUEUE_DEPTH 4

`endif

/* rtl/addrgen_pkg.sv */
// Address generator types
`include "addrgen_defs.svh"

package addrgen_pkg;

  // Element width, log2 of the byte count
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Unit-stride and strided loads and stores
  typedef enum logic [1:0] {
    VLE  = 2'd0,
    VSE  = 2'd1,
    VLSE = 2'd2,
    VSSE = 2'd3
  } mem_op_e;

  // Instruction from the sequencer
  typedef struct packed {
    mem_op_e             op;
    logic [`ADDR_W-1:0]  addr;
    logic [`ADDR_W-1:0]  stride;
    logic [`VL_W-1:0]    vl;
    vew_e                vew;
  } pe_req_t;

  // Work item handed from controller to generator
  typedef struct packed {
    logic [`ADDR_W-1:0]  addr;
    logic [`VL_W-1:0]    len;
    logic [`ADDR_W-1:0]  stride;
    vew_e                vew;
    logic                is_load;
    logic                is_burst;
  } ag_job_t;

  // AR or AW request, len counts beats minus one
  typedef struct packed {
    logic [`ADDR_W-1:0]  addr;
    logic [7:0]          len;
    logic [2:0]          size;
  } ax_req_t;

  // Entry for the load/store units
  typedef struct packed {
    logic [`ADDR_W-1:0]  addr;
    logic [7:0]          len;
    logic [2:0]          size;
    logic                is_load;
  } lsu_req_t;

endpackage

/* rtl/req_fifo.sv */
// Request queue
module req_fifo #(
  parameter type         dtype = logic,
  parameter int unsigned DEPTH = 4
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  dtype data_i,
  input  logic push_i,
  output logic full_o,
  output dtype data_o,
  input  logic pop_i,
  output logic empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  // Storage, no reset needed
  dtype mem_q [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             do_push, do_pop;

  // Writes into a full queue and reads from an empty one are dropped
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  assign full_o  = (cnt_q == CNT_W'(DEPTH));
  assign empty_o = (cnt_q == '0);

  // Head of the queue, shown combinationally
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Pointers wrap explicitly so any depth works
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Fill count, unchanged on simultaneous push and pop
      if (do_push && !do_pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (do_pop && !do_push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

endmodule

/* rtl/burst_bound.sv */
// Burst length limiter
`include "addrgen_defs.svh"

module burst_bound (
  input  logic [`ADDR_W-1:0]                 addr_i,
  input  logic [`VL_W+2:0]                   bytes_i,
  output logic [$clog2(`MAX_BURST_BEATS):0]  beats_o,
  output logic [`ADDR_W-1:0]                 next_addr_o
);

  // Everything below is counted in beats, not bytes
  localparam int unsigned BW = `ADDR_W - `BUS_SIZE_LOG;
  localparam int unsigned PG = `PAGE_BITS - `BUS_SIZE_LOG;

  logic [`ADDR_W-1:0] end_byte;
  logic [BW-1:0]      start_beat, last_beat;
  logic [BW-1:0]      data_beats, page_beats, beats;

  // Aligned start, low address bits dropped
  assign start_beat = addr_i[`ADDR_W-1:`BUS_SIZE_LOG];

  // Last byte of the remaining data, rounded to its beat
  assign end_byte   = addr_i + `ADDR_W'(bytes_i) - `ADDR_W'(1);
  assign last_beat  = end_byte[`ADDR_W-1:`BUS_SIZE_LOG];
  assign data_beats = last_beat - start_beat + BW'(1);

  // Beats left before the 4 KiB boundary
  assign page_beats = BW'(1 << PG) - BW'(start_beat[PG-1:0]);

  // Smallest of data end, page end and the burst cap
  always_comb begin
    beats = data_beats;
    if (page_beats < beats) begin
      beats = page_beats;
    end
    if (BW'(`MAX_BURST_BEATS) < beats) begin
      beats = BW'(`MAX_BURST_BEATS);
    end
  end

  assign beats_o     = ($clog2(`MAX_BURST_BEATS) + 1)'(beats);

  // Following burst starts on a bus-aligned address
  assign next_addr_o = {start_beat + beats, {`BUS_SIZE_LOG{1'b0}}};

endmodule

/* rtl/ax_req_gen.sv */
// AR/AW request generator
`include "addrgen_defs.svh"

module ax_req_gen import addrgen_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  ag_job_t  job_i,
  input  logic     job_valid_i,
  output logic     job_done_o,
  input  logic     core_st_pending_i,
  output ax_req_t  ar_o,
  output ax_req_t  aw_o,
  output logic     ar_valid_o,
  output logic     aw_valid_o,
  input  logic     ar_ready_i,
  input  logic     aw_ready_i,
  input  logic     q_full_i,
  input  logic     q_empty_i,
  input  logic     q_head_is_load_i,
  output logic     q_push_o,
  output lsu_req_t q_data_o
);

  typedef enum logic [1:0] {S_IDLE, S_ARB, S_REQ} state_e;

  state_e  state_q, state_d;
  ag_job_t job_q, job_d;
  ax_req_t ax_q, ax_d;
  logic    ar_valid_q, ar_valid_d;
  logic    aw_valid_q, aw_valid_d;
  logic    job_done_q, job_done_d;

  // Address and count after the request in flight
  logic [`ADDR_W-1:0] nxt_addr_q, nxt_addr_d;
  logic [`VL_W-1:0]   nxt_len_q, nxt_len_d;

  logic [`VL_W+2:0]                  rem_bytes;
  logic [$clog2(`MAX_BURST_BEATS):0] bb_beats;
  logic [`ADDR_W-1:0]                bb_next_addr;
  logic [`ADDR_W-1:0]                covered;
  logic                              dir_ok, can_issue, hs;

  //////////////////////////////////////////////////
  // Burst sizing
  //////////////////////////////////////////////////

  assign rem_bytes = (`VL_W+3)'(job_q.len) << job_q.vew;

  burst_bound burst_bound_i (
    .addr_i      (job_q.addr),
    .bytes_i     (rem_bytes),
    .beats_o     (bb_beats),
    .next_addr_o (bb_next_addr)
  );

  // Elements covered by this burst
  assign covered = (bb_next_addr - job_q.addr) >> job_q.vew;

  //////////////////////////////////////////////////
  // Issue conditions
  //////////////////////////////////////////////////

  // No direction change until the queue drains
  assign dir_ok    = q_empty_i || (q_head_is_load_i == job_q.is_load);
  assign can_issue = !q_full_i && !core_st_pending_i && dir_ok;

  // Handshake also pushes the request to the queue
  assign hs        = (ar_valid_q && ar_ready_i) || (aw_valid_q && aw_ready_i);
  assign q_push_o  = hs;
  assign q_data_o  = '{addr: ax_q.addr, len: ax_q.len, size: ax_q.size,
                       is_load: job_q.is_load};

  assign ar_o       = ax_q;
  assign aw_o       = ax_q;
  assign ar_valid_o = ar_valid_q;
  assign aw_valid_o = aw_valid_q;
  assign job_done_o = job_done_q;

  always_comb begin
    state_d    = state_q;
    job_d      = job_q;
    ax_d       = ax_q;
    ar_valid_d = ar_valid_q;
    aw_valid_d = aw_valid_q;
    nxt_addr_d = nxt_addr_q;
    nxt_len_d  = nxt_len_q;
    job_done_d = 1'b0;

    case (state_q)
      S_IDLE: begin
        if (job_valid_i) begin
          job_d   = job_i;
          state_d = S_ARB;
        end
      end

      S_ARB: begin
        // Empty vector finishes without traffic
        if (job_q.len == '0) begin
          job_done_d = 1'b1;
          state_d    = S_IDLE;
        end else if (can_issue) begin
          ax_d.addr = job_q.addr;
          if (job_q.is_burst) begin
            // Incrementing burst over full bus beats
            ax_d.len   = 8'(bb_beats - 1'b1);
            ax_d.size  = 3'(`BUS_SIZE_LOG);
            nxt_addr_d = bb_next_addr;
            nxt_len_d  = (`ADDR_W'(job_q.len) > covered) ?
                         job_q.len - `VL_W'(covered) : '0;
          end else begin
            // One element per request
            ax_d.len   = 8'd0;
            ax_d.size  = {1'b0, job_q.vew};
            nxt_addr_d = job_q.addr + job_q.stride;
            nxt_len_d  = job_q.len - 1'b1;
          end
          ar_valid_d = job_q.is_load;
          aw_valid_d = !job_q.is_load;
          state_d    = S_REQ;
        end
      end

      S_REQ: begin
        // Valid and data held until ready
        if (hs) begin
          ar_valid_d = 1'b0;
          aw_valid_d = 1'b0;
          job_d.addr = nxt_addr_q;
          job_d.len  = nxt_len_q;
          if (nxt_len_q == '0) begin
            job_done_d = 1'b1;
            state_d    = S_IDLE;
          end else begin
            state_d    = S_ARB;
          end
        end
      end

      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= S_IDLE;
      ar_valid_q <= 1'b0;
      aw_valid_q <= 1'b0;
      job_done_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      ar_valid_q <= ar_valid_d;
      aw_valid_q <= aw_valid_d;
      job_done_q <= job_done_d;
    end
  end

  // Payload registers
  always_ff @(posedge clk_i) begin
    job_q      <= job_d;
    ax_q       <= ax_d;
    nxt_addr_q <= nxt_addr_d;
    nxt_len_q  <= nxt_len_d;
  end

endmodule

/* rtl/addrgen_ctrl.sv */
// Instruction controller
module addrgen_ctrl import addrgen_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  pe_req_t pe_req_i,
  input  logic    pe_req_valid_i,
  output ag_job_t job_o,
  output logic    job_valid_o,
  input  logic    job_done_i,
  output logic    ack_o,
  output logic    exc_o,
  output logic    exc_load_o,
  output logic    exc_store_o
);

  typedef enum logic [1:0] {IDLE, CHECK, RUN, DONE} state_e;

  state_e  state_q, state_d;
  pe_req_t req_q;
  logic    misaligned, is_load, capture;
  logic    ack_q, exc_q, exc_ld_q, exc_st_q;

  // Base must be aligned to the element width
  function automatic logic addr_misaligned(input logic [2:0] lsb, input vew_e vew);
    case (vew)
      EW16:    addr_misaligned = lsb[0];
      EW32:    addr_misaligned = |lsb[1:0];
      EW64:    addr_misaligned = |lsb;
      default: addr_misaligned = 1'b0;
    endcase
  endfunction

  assign misaligned = addr_misaligned(req_q.addr[2:0], req_q.vew);
  assign is_load    = req_q.op inside {VLE, VLSE};

  // Ignore the held request during the acknowledge cycle
  assign capture    = (state_q == IDLE) && pe_req_valid_i && !ack_q;

  // Unit stride becomes bursts in the job for the generator
  assign job_o = '{addr: req_q.addr, len: req_q.vl, stride: req_q.stride,
                   vew: req_q.vew, is_load: is_load,
                   is_burst: req_q.op inside {VLE, VSE}};
  assign job_valid_o = (state_q == CHECK) && !misaligned;

  assign ack_o       = ack_q;
  assign exc_o       = exc_q;
  assign exc_load_o  = exc_ld_q;
  assign exc_store_o = exc_st_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:  if (capture) state_d = CHECK;
      CHECK: state_d = misaligned ? DONE : RUN;
      // Normal completion acknowledges straight from here
      RUN:   if (job_done_i) state_d = IDLE;
      DONE:  state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      ack_q    <= 1'b0;
      exc_q    <= 1'b0;
      exc_ld_q <= 1'b0;
      exc_st_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      // One-cycle acknowledge with the exception flags alongside
      ack_q    <= (state_q == DONE) || ((state_q == RUN) && job_done_i);
      // Only a misaligned base reaches DONE
      exc_q    <= (state_q == DONE);
      exc_ld_q <= (state_q == DONE) && is_load;
      exc_st_q <= (state_q == DONE) && !is_load;
    end
  end

  // Instruction register
  always_ff @(posedge clk_i) begin
    if (capture) begin
      req_q <= pe_req_i;
    end
  end

endmodule

/* rtl/addrgen_top.sv */
// Vector address generator
`include "addrgen_defs.svh"

module addrgen_top import addrgen_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  pe_req_t  pe_req_i,
  input  logic     pe_req_valid_i,
  output logic     ack_o,
  output logic     exc_o,
  output logic     exc_load_o,
  output logic     exc_store_o,
  input  logic     core_st_pending_i,
  output ax_req_t  ar_o,
  output logic     ar_valid_o,
  input  logic     ar_ready_i,
  output ax_req_t  aw_o,
  output logic     aw_valid_o,
  input  logic     aw_ready_i,
  output lsu_req_t lsu_req_o,
  output logic     lsu_req_valid_o,
  input  logic     lsu_req_ready_i
);

  ag_job_t  job;
  logic     job_valid, job_done;
  logic     q_push, q_full, q_empty;
  lsu_req_t q_data;

  assign lsu_req_valid_o = !q_empty;

  addrgen_ctrl addrgen_ctrl_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .pe_req_i       (pe_req_i),
    .pe_req_valid_i (pe_req_valid_i),
    .job_o          (job),
    .job_valid_o    (job_valid),
    .job_done_i     (job_done),
    .ack_o          (ack_o),
    .exc_o          (exc_o),
    .exc_load_o     (exc_load_o),
    .exc_store_o    (exc_store_o)
  );

  // Head direction gates direction changes
  ax_req_gen ax_req_gen_i (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .job_i             (job),
    .job_valid_i       (job_valid),
    .job_done_o        (job_done),
    .core_st_pending_i (core_st_pending_i),
    .ar_o              (ar_o),
    .aw_o              (aw_o),
    .ar_valid_o        (ar_valid_o),
    .aw_valid_o        (aw_valid_o),
    .ar_ready_i        (ar_ready_i),
    .aw_ready_i        (aw_ready_i),
    .q_full_i          (q_full),
    .q_empty_i         (q_empty),
    .q_head_is_load_i  (lsu_req_o.is_load),
    .q_push_o          (q_push),
    .q_data_o          (q_data)
  );

  req_fifo #(
    .dtype (lsu_req_t),
    .DEPTH (`QUEUE_DEPTH)
  ) req_fifo_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .data_i  (q_data),
    .push_i  (q_push),
    .full_o  (q_full),
    .data_o  (lsu_req_o),
    .pop_i   (lsu_req_ready_i),
    .empty_o (q_empty)
  );

endmodule

/* test/addrgen_props.sv */
// Address generator port properties
module addrgen_props import addrgen_pkg::*; (
  input logic    clk_i,
  input logic    rst_ni,
  input ax_req_t ar_o,
  input logic    ar_valid_o,
  input logic    ar_ready_i,
  input ax_req_t aw_o,
  input logic    aw_valid_o,
  input logic    aw_ready_i,
  input logic    ack_o,
  input logic    exc_o
);

  // One job at a time, so never both channels at once
  a_one_channel: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(ar_valid_o && aw_valid_o))
    else $error("AR and AW valid high in the same cycle");

  // AR request held until accepted
  a_ar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o))
    else $error("AR request changed before ar_ready_i");

  a_aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_o))
    else $error("AW request changed before aw_ready_i");

  // Exception only on the acknowledge pulse
  a_exc_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    exc_o |-> ack_o)
    else $error("exc_o high without ack_o");

endmodule

bind addrgen_top addrgen_props addrgen_props_i (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .ar_o       (ar_o),
  .ar_valid_o (ar_valid_o),
  .ar_ready_i (ar_ready_i),
  .aw_o       (aw_o),
  .aw_valid_o (aw_valid_o),
  .aw_ready_i (aw_ready_i),
  .ack_o      (ack_o),
  .exc_o      (exc_o)
);

/* test/tb_addrgen.sv */
// Address generator testbench
module tb_addrgen import addrgen_pkg::*; ();

  localparam int ACK_TIMEOUT   = 2000;
  localparam int DRAIN_TIMEOUT = 400;

  logic     clk_i = 1'b0;
  logic     rst_ni, pe_req_valid_i, core_st_pending_i;
  logic     ack_o, exc_o, exc_load_o, exc_store_o;
  logic     ar_valid_o, aw_valid_o, lsu_req_valid_o;
  logic     ar_ready_i, aw_ready_i, lsu_req_ready_i;
  pe_req_t  pe_req_i;
  ax_req_t  ar_o, aw_o;
  lsu_req_t lsu_req_o;

  // Observed handshakes and expected requests
  ax_req_t  ar_seen[$], aw_seen[$], exp_q[$];
  lsu_req_t lsu_seen[$];
  int       err_cnt = 0;
  int       to_cnt  = 0;

  addrgen_top addrgen_top_i (.*);

  always #50 clk_i = ~clk_i;

  // Random back-pressure on all ready inputs
  initial begin : ready_drive
    logic [31:0] rnd;
    rnd = $urandom(32'haeaf);
    ar_ready_i      <= 1'b0;
    aw_ready_i      <= 1'b0;
    lsu_req_ready_i <= 1'b0;
    forever begin
      @(posedge clk_i);
      rnd = $urandom();
      ar_ready_i      <= rnd[0];
      aw_ready_i      <= rnd[1];
      lsu_req_ready_i <= (rnd[3:2] != 2'b00);
    end
  end

  // Handshake monitors
  always @(posedge clk_i) begin
    if (ar_valid_o && ar_ready_i) ar_seen.push_back(ar_o);
    if (aw_valid_o && aw_ready_i) aw_seen.push_back(aw_o);
    if (lsu_req_valid_o && lsu_req_ready_i) lsu_seen.push_back(lsu_req_o);
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  task automatic build_expected(input pe_req_t req);
    logic [31:0] addr, rem, bytes, aligned, stop, lim, covered;
    ax_req_t     r;
    int          i;
    exp_q.delete();
    addr = req.addr;
    if (req.op inside {VLE, VSE}) begin
      rem = 32'(req.vl);
      while (rem != 32'd0) begin
        bytes   = rem << req.vew;
        aligned = addr & ~32'h7;
        // Burst ends at the nearest of data end, page end and 256 beats
        stop    = (addr + bytes + 32'd7) & ~32'h7;
        lim     = {aligned[31:12] + 20'd1, 12'h000};
        if (lim < stop) stop = lim;
        lim     = aligned + 32'd2048;
        if (lim < stop) stop = lim;
        r.addr  = addr;
        r.len   = 8'(((stop - aligned) >> 3) - 32'd1);
        r.size  = 3'd3;
        exp_q.push_back(r);
        covered = (stop - addr) >> req.vew;
        rem     = (covered >= rem) ? 32'd0 : rem - covered;
        addr    = stop;
      end
    end else begin
      for (i = 0; i < int'(req.vl); i++) begin
        r.addr = req.addr + 32'(i) * req.stride;
        r.len  = 8'd0;
        r.size = {1'b0, req.vew};
        exp_q.push_back(r);
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Bounded waits
  //////////////////////////////////////////////////

  task automatic wait_ack(output int cycles, output bit ok);
    ok     = 1'b0;
    cycles = 0;
    while (!ok && cycles < ACK_TIMEOUT) begin
      @(posedge clk_i);
      cycles++;
      if (ack_o) ok = 1'b1;
    end
    if (!ok) begin
      $display("TIMEOUT: no acknowledge after %0d cycles", ACK_TIMEOUT);
      to_cnt++;
    end
  endtask

  // Sampled on the falling edge away from the monitor updates
  task automatic wait_drain(input int target, output bit ok);
    int cycles;
    cycles = 0;
    ok     = (lsu_seen.size() >= target);
    while (!ok && cycles < DRAIN_TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
      ok = (lsu_seen.size() >= target);
    end
    if (!ok) begin
      $display("TIMEOUT: load/store queue did not deliver %0d entries", target);
      to_cnt++;
    end
  endtask

  //////////////////////////////////////////////////
  // Test tasks
  //////////////////////////////////////////////////

  // One legal instruction optionally behind a pending scalar store
  task automatic run_instr(input string name, input pe_req_t req, input int hold);
    bit   ok;
    int   cycles, i, n, ar_base, aw_base, lsu_base, errs;
    logic is_load;
    ax_req_t got;
    $display("Test: %s", name);
    build_expected(req);
    is_load = req.op inside {VLE, VLSE};
    n       = exp_q.size();
    @(negedge clk_i);
    ar_base  = ar_seen.size();
    aw_base  = aw_seen.size();
    lsu_base = lsu_seen.size();
    @(posedge clk_i);
    pe_req_i       <= req;
    pe_req_valid_i <= 1'b1;
    if (hold > 0) core_st_pending_i <= 1'b1;
    for (i = 0; i < hold; i++) begin
      @(posedge clk_i);
      check_val("ar_valid_o", 32'(ar_valid_o), 32'd0);
      check_val("aw_valid_o", 32'(aw_valid_o), 32'd0);
    end
    core_st_pending_i <= 1'b0;
    wait_ack(cycles, ok);
    pe_req_valid_i <= 1'b0;
    if (!ok) return;
    check_val("exc_o", 32'(exc_o), 32'd0);
    check_val("exc_load_o", 32'(exc_load_o), 32'd0);
    check_val("exc_store_o", 32'(exc_store_o), 32'd0);
    wait_drain(lsu_base + n, ok);
    if (!ok) return;
    // Requests on the matching channel only
    errs = err_cnt;
    check_val("ar count", 32'(ar_seen.size() - ar_base), is_load ? 32'(n) : 32'd0);
    check_val("aw count", 32'(aw_seen.size() - aw_base), is_load ? 32'd0 : 32'(n));
    check_val("lsu count", 32'(lsu_seen.size() - lsu_base), 32'(n));
    if (err_cnt != errs) return;
    for (i = 0; i < n; i++) begin
      got = is_load ? ar_seen[ar_base + i] : aw_seen[aw_base + i];
      check_val($sformatf("ax.addr[%0d]", i), got.addr, exp_q[i].addr);
      check_val($sformatf("ax.len[%0d]", i), 32'(got.len), 32'(exp_q[i].len));
      check_val($sformatf("ax.size[%0d]", i), 32'(got.size), 32'(exp_q[i].size));
      check_val($sformatf("lsu.addr[%0d]", i), lsu_seen[lsu_base + i].addr, exp_q[i].addr);
      check_val($sformatf("lsu.len[%0d]", i), 32'(lsu_seen[lsu_base + i].len),
                32'(exp_q[i].len));
      check_val($sformatf("lsu.size[%0d]", i), 32'(lsu_seen[lsu_base + i].size),
                32'(exp_q[i].size));
      check_val($sformatf("lsu.is_load[%0d]", i), 32'(lsu_seen[lsu_base + i].is_load),
                32'(is_load));
    end
  endtask

  // Misaligned base is refused with an exception and no traffic
  task automatic misaligned_instr(input string name, input pe_req_t req);
    bit   ok;
    int   cycles, ar_base, aw_base, lsu_base;
    logic is_load;
    $display("Test: %s", name);
    is_load = req.op inside {VLE, VLSE};
    @(negedge clk_i);
    ar_base  = ar_seen.size();
    aw_base  = aw_seen.size();
    lsu_base = lsu_seen.size();
    @(posedge clk_i);
    pe_req_i       <= req;
    pe_req_valid_i <= 1'b1;
    wait_ack(cycles, ok);
    pe_req_valid_i <= 1'b0;
    if (!ok) return;
    // Pulse rises two edges after capture and is seen at the next one
    check_val("ack latency", 32'(cycles), 32'd4);
    check_val("exc_o", 32'(exc_o), 32'd1);
    check_val("exc_load_o", 32'(exc_load_o), 32'(is_load));
    check_val("exc_store_o", 32'(exc_store_o), 32'(!is_load));
    repeat (4) @(negedge clk_i);
    check_val("ar count", 32'(ar_seen.size() - ar_base), 32'd0);
    check_val("aw count", 32'(aw_seen.size() - aw_base), 32'd0);
    check_val("lsu count", 32'(lsu_seen.size() - lsu_base), 32'd0);
  endtask

  initial begin
    rst_ni            <= 1'b0;
    pe_req_i          <= '0;
    pe_req_valid_i    <= 1'b0;
    core_st_pending_i <= 1'b0;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (2) @(posedge clk_i);

    run_instr("short load", pe_req_t'{op: VLE, addr: 32'h1000_0040, stride: 32'd0,
              vl: 10'd16, vew: EW32}, 0);
    run_instr("page crossing store", pe_req_t'{op: VSE, addr: 32'h0000_0FC0, stride: 32'd0,
              vl: 10'd32, vew: EW32}, 0);
    // 4096 bytes from mid page give three bursts
    run_instr("long load", pe_req_t'{op: VLE, addr: 32'h0002_0100, stride: 32'd0,
              vl: 10'd512, vew: EW64}, 0);
    run_instr("strided store", pe_req_t'{op: VSSE, addr: 32'h2000_0004, stride: 32'h24,
              vl: 10'd6, vew: EW32}, 0);
    misaligned_instr("misaligned load", pe_req_t'{op: VLE, addr: 32'h1000_0002,
                     stride: 32'd0, vl: 10'd4, vew: EW32});
    misaligned_instr("misaligned store", pe_req_t'{op: VSSE, addr: 32'h1000_0001,
                     stride: 32'd8, vl: 10'd4, vew: EW16});
    run_instr("store pending", pe_req_t'{op: VLE, addr: 32'h3000_0000, stride: 32'd0,
              vl: 10'd8, vew: EW64}, 20);

    $display("Errors: %0d check failures, %0d timeouts", err_cnt, to_cnt);
    if (err_cnt == 0 && to_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+rtl
rtl/addrgen_pkg.sv
rtl/req_fifo.sv
rtl/burst_bound.sv
rtl/ax_req_gen.sv
rtl/addrgen_ctrl.sv
rtl/addrgen_top.sv
test/addrgen_props.sv
test/tb_addrgen.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module tb_addrgen -f build.f &&
./obj_dir/Vtb_addrgen | tee /dev/stderr | grep -x "sim passed" > /dev/null &&
echo "PASS" || { echo "FAIL"; exit 1; }
